// File: project.f
+incdir+include
verilog/rvc_pkg.sv
verilog/rvc_quadrant0.sv
verilog/rvc_quadrant1.sv
verilog/rvc_quadrant2.sv
verilog/rvc_decode_reg.sv
verilog/rvc_decoder.sv
bench/tb_rvc_decoder.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the RVC decoder testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f project.f --top-module tb_rvc_decoder \
    --Mdir obj_dir -o tb_rvc_decoder
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_rvc_decoder > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
    exit 1
fi
exit 0

// File: include/rvc_tests.svh
/*
 * RVC decoder directed tests
 * Instruction encoders following the RVC field layout and one task per
 * test group, each sending instructions back to back.
 */
`ifndef RVC_TESTS_SVH
`define RVC_TESTS_SVH

// generic 16-bit layout, funct3 | bit 12 | bits 11:7 | bits 6:2 | quadrant
function automatic rvc_pkg::rvc_instr_t enc(input logic [2:0] f3, input logic b12,
                                            input logic [4:0] hi, input logic [4:0] lo,
                                            input logic [1:0] quad);
    return {f3, b12, hi, lo, quad};
endfunction

// x8..x15 from a 3-bit field
function automatic rvc_pkg::reg_addr_t creg(input logic [2:0] f);
    return rvc_pkg::PRIME_BASE + {3'b000, f};
endfunction

function automatic logic [4:0] nz_reg(input logic [4:0] v);
    return (v == 5'd0) ? 5'd1 : v;
endfunction

task automatic test_reset();
    begin_test("reset");
    repeat (RESET_CYCLES - 1) @(posedge i_clk);
    @(negedge i_clk);
    check_rec('0);                                  // held in reset
    @(posedge i_clk);
    i_nrst <= 1'b1;
    @(negedge i_clk);
    check_rec('0);                                  // first cycle after release
    end_test();
endtask

task automatic test_quadrant0();
    logic [31:0] r;
    begin_test("quadrant0");
    repeat (6) begin
        r = xorshift32();                           // r[2:0] rd', r[5:3] rs1'
        issue(enc(3'b000, r[9], {r[8], r[13:10]}, {r[6], r[7], r[2:0]}, 2'b00),
              expect_rec(rvc_pkg::FMT_I, rvc_pkg::OP_ADDI, rvc_pkg::REG_SP, 6'd0,
                         creg(r[2:0]), {54'd0, r[13:6], 2'b00}));
        issue(enc(3'b010, r[9], {r[8:7], r[5:3]}, {r[6], r[10], r[2:0]}, 2'b00),
              expect_rec(rvc_pkg::FMT_I, rvc_pkg::OP_LW, creg(r[5:3]), 6'd0,
                         creg(r[2:0]), {57'd0, r[10:6], 2'b00}));
        issue(enc(3'b011, r[8], {r[7:6], r[5:3]}, {r[10:9], r[2:0]}, 2'b00),
              expect_rec(rvc_pkg::FMT_I, rvc_pkg::OP_LD, creg(r[5:3]), 6'd0,
                         creg(r[2:0]), {56'd0, r[10:6], 3'b000}));
        issue(enc(3'b110, r[9], {r[8:7], r[5:3]}, {r[6], r[10], r[2:0]}, 2'b00),
              expect_rec(rvc_pkg::FMT_S, rvc_pkg::OP_SW, creg(r[5:3]), creg(r[2:0]),
                         6'd0, {57'd0, r[10:6], 2'b00}));
        issue(enc(3'b111, r[8], {r[7:6], r[5:3]}, {r[10:9], r[2:0]}, 2'b00),
              expect_rec(rvc_pkg::FMT_S, rvc_pkg::OP_SD, creg(r[5:3]), creg(r[2:0]),
                         6'd0, {56'd0, r[10:6], 3'b000}));
    end
    end_test();
endtask

task automatic test_quadrant1_imm();
    logic [31:0] r;
    logic [4:0]  rd;
    logic [4:0]  rdl;
    logic [5:0]  v6;
    begin_test("quadrant1_imm");
    repeat (6) begin
        r = xorshift32();
        rd = r[4:0];
        rdl = (rd == 5'd2) ? 5'd3 : rd;             // rd = sp would select addi16sp
        v6 = r[10:5];
        issue(enc(3'b000, v6[5], rd, v6[4:0], 2'b01),
              expect_rec(rvc_pkg::FMT_I, rvc_pkg::OP_ADDI, {1'b0, rd}, 6'd0,
                         {1'b0, rd}, 64'($signed(v6))));
        issue(enc(3'b001, v6[5], rd, v6[4:0], 2'b01),
              expect_rec(rvc_pkg::FMT_I, rvc_pkg::OP_ADDIW, {1'b0, rd}, 6'd0,
                         {1'b0, rd}, 64'($signed(v6))));
        issue(enc(3'b010, v6[5], rd, v6[4:0], 2'b01),
              expect_rec(rvc_pkg::FMT_I, rvc_pkg::OP_ADDI, 6'd0, 6'd0,
                         {1'b0, rd}, 64'($signed(v6))));
        issue(enc(3'b011, v6[5], rdl, v6[4:0], 2'b01),
              expect_rec(rvc_pkg::FMT_U, rvc_pkg::OP_LUI, 6'd0, 6'd0,
                         {1'b0, rdl}, 64'($signed({v6, 12'h000}))));
        issue(enc(3'b011, v6[5], 5'd2, {v6[0], v6[2], v6[4:3], v6[1]}, 2'b01),
              expect_rec(rvc_pkg::FMT_I, rvc_pkg::OP_ADDI, rvc_pkg::REG_SP, 6'd0,
                         rvc_pkg::REG_SP, 64'($signed({v6, 4'b0000}))));
        issue(enc(3'b101, r[26], {r[19], r[24:23], r[25], r[21]}, {r[22], r[18:16], r[20]},
                  2'b01),
              expect_rec(rvc_pkg::FMT_UJ, rvc_pkg::OP_JAL, 6'd0, 6'd0, 6'd0,
                         64'($signed({r[26:16], 1'b0}))));
        issue(enc(3'b110, r[23], {r[19:18], r[29:27]}, {r[22:21], r[17:16], r[20]}, 2'b01),
              expect_rec(rvc_pkg::FMT_SB, rvc_pkg::OP_BEQ, creg(r[29:27]), 6'd0, 6'd0,
                         64'($signed({r[23:16], 1'b0}))));
        issue(enc(3'b111, r[23], {r[19:18], r[29:27]}, {r[22:21], r[17:16], r[20]}, 2'b01),
              expect_rec(rvc_pkg::FMT_SB, rvc_pkg::OP_BNE, creg(r[29:27]), 6'd0, 6'd0,
                         64'($signed({r[23:16], 1'b0}))));
    end
    end_test();
endtask

task automatic test_math_group();
    logic [31:0]      r;
    logic [2:0]       code;
    rvc_pkg::rvc_op_e reg_ops [6];
    begin_test("math_group");
    reg_ops = '{rvc_pkg::OP_SUB, rvc_pkg::OP_XOR, rvc_pkg::OP_OR, rvc_pkg::OP_AND,
                rvc_pkg::OP_SUBW, rvc_pkg::OP_ADDW};
    repeat (2) begin
        r = xorshift32();                           // r[2:0] rs1', r[5:3] rs2'
        issue(enc(3'b100, r[11], {2'b00, r[2:0]}, r[10:6], 2'b01),
              expect_rec(rvc_pkg::FMT_I, rvc_pkg::OP_SRLI, creg(r[2:0]), 6'd0,
                         creg(r[2:0]), {58'd0, r[11:6]}));
        issue(enc(3'b100, r[11], {2'b01, r[2:0]}, r[10:6], 2'b01),
              expect_rec(rvc_pkg::FMT_I, rvc_pkg::OP_SRAI, creg(r[2:0]), 6'd0,
                         creg(r[2:0]), {58'd0, r[11:6]}));
        issue(enc(3'b100, r[11], {2'b10, r[2:0]}, r[10:6], 2'b01),
              expect_rec(rvc_pkg::FMT_I, rvc_pkg::OP_ANDI, creg(r[2:0]), 6'd0,
                         creg(r[2:0]), 64'($signed(r[11:6]))));
        for (int c = 0; c < 8; c++) begin
            code = 3'(c);                           // {bit 12, bits 6:5}
            issue(enc(3'b100, code[2], {2'b11, r[2:0]}, {code[1:0], r[5:3]}, 2'b01),
                  (c < 6) ? expect_rec(rvc_pkg::FMT_R, reg_ops[c], creg(r[2:0]),
                                       creg(r[5:3]), creg(r[2:0]), 64'd0)
                          : expect_illegal());
        end
    end
    end_test();
endtask

task automatic test_quadrant2();
    logic [31:0] r;
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [5:0]  u;
    begin_test("quadrant2");
    repeat (4) begin
        r = xorshift32();
        rd = nz_reg(r[4:0]);
        rs2 = nz_reg(r[9:5]);
        u = r[15:10];
        issue(enc(3'b100, 1'b0, rd, 5'd0, 2'b10),  // jr
              expect_rec(rvc_pkg::FMT_I, rvc_pkg::OP_JALR, {1'b0, rd}, 6'd0, 6'd0, 64'd0));
        issue(enc(3'b100, 1'b0, rd, rs2, 2'b10),   // mv
              expect_rec(rvc_pkg::FMT_I, rvc_pkg::OP_ADDI, {1'b0, rs2}, 6'd0, {1'b0, rd},
                         64'd0));
        issue(enc(3'b100, 1'b1, 5'd0, 5'd0, 2'b10),
              expect_rec(rvc_pkg::FMT_I, rvc_pkg::OP_EBREAK, 6'd0, 6'd0, 6'd0, 64'd0));
        issue(enc(3'b100, 1'b1, rd, 5'd0, 2'b10),  // jalr links into ra
              expect_rec(rvc_pkg::FMT_I, rvc_pkg::OP_JALR, {1'b0, rd}, 6'd0,
                         rvc_pkg::REG_RA, 64'd0));
        issue(enc(3'b100, 1'b1, rd, rs2, 2'b10),
              expect_rec(rvc_pkg::FMT_R, rvc_pkg::OP_ADD, {1'b0, rd}, {1'b0, rs2},
                         {1'b0, rd}, 64'd0));
        issue(enc(3'b000, u[5], rd, u[4:0], 2'b10),
              expect_rec(rvc_pkg::FMT_I, rvc_pkg::OP_SLLI, {1'b0, rd}, 6'd0, {1'b0, rd},
                         {58'd0, u}));
        issue(enc(3'b010, u[3], rd, {u[2:0], u[5:4]}, 2'b10),
              expect_rec(rvc_pkg::FMT_I, rvc_pkg::OP_LW, rvc_pkg::REG_SP, 6'd0, {1'b0, rd},
                         {56'd0, u, 2'b00}));
        issue(enc(3'b011, u[2], rd, {u[1:0], u[5:3]}, 2'b10),
              expect_rec(rvc_pkg::FMT_I, rvc_pkg::OP_LD, rvc_pkg::REG_SP, 6'd0, {1'b0, rd},
                         {55'd0, u, 3'b000}));
        issue(enc(3'b110, u[3], {u[2:0], u[5:4]}, rs2, 2'b10),
              expect_rec(rvc_pkg::FMT_S, rvc_pkg::OP_SW, rvc_pkg::REG_SP, {1'b0, rs2}, 6'd0,
                         {56'd0, u, 2'b00}));
        issue(enc(3'b111, u[2], {u[1:0], u[5:3]}, rs2, 2'b10),
              expect_rec(rvc_pkg::FMT_S, rvc_pkg::OP_SD, rvc_pkg::REG_SP, {1'b0, rs2}, 6'd0,
                         {55'd0, u, 3'b000}));
    end
    end_test();
endtask

task automatic test_pipeline();
    logic [31:0] r;
    begin_test("pipeline_flush");
    repeat (16) begin                               // c.li with random pc and faults
        r = xorshift32();
        next_pc = {xorshift32(), r[31:1], 1'b0};
        send(enc(3'b010, r[10], r[4:0], r[9:5], 2'b01), r[11], r[12], 1'b0,
             expect_rec(rvc_pkg::FMT_I, rvc_pkg::OP_ADDI, 6'd0, 6'd0, {1'b0, r[4:0]},
                        64'($signed(r[10:5]))));
    end
    r = xorshift32();
    send({r[15:2], 2'b11}, r[16], r[17], 1'b0, expect_illegal());
    send(enc(3'b010, 1'b0, 5'd9, 5'd3, 2'b01), 1'b1, 1'b1, 1'b1, '0);
    issue(enc(3'b010, 1'b1, 5'd10, 5'd4, 2'b01),  // decodes normally after flush
          expect_rec(rvc_pkg::FMT_I, rvc_pkg::OP_ADDI, 6'd0, 6'd0, 6'd10,
                     64'($signed(6'b100100))));
    end_test();
endtask

`endif

// File: bench/tb_rvc_decoder.sv
/*
 * RVC decoder testbench
 * Drives one compressed instruction per clock and checks each decoded
 * record one cycle later against values built from the RVC field layout.
 */
`timescale 1ns/1ps

module tb_rvc_decoder;

    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 4;
    localparam int NUM_VECTORS = 220;               // upper bound over all tests
    localparam int TIMEOUT_NS = NUM_VECTORS * CLK_PERIOD * 4 + RESET_CYCLES * CLK_PERIOD;

    logic                i_clk = 1'b0;
    logic                i_nrst;
    logic                i_flush;
    rvc_pkg::xlen_t      i_pc;
    rvc_pkg::rvc_instr_t i_instr;
    logic                i_load_fault;
    logic                i_page_fault;
    rvc_pkg::rvc_dec_t   o_dec;

    logic [31:0]         rng_state;
    rvc_pkg::xlen_t      next_pc;
    rvc_pkg::rvc_dec_t   pend_exp;                  // record due at the next check
    logic                pend_valid;
    int                  err_count;
    int                  test_err_base;
    int                  tests_run;
    int                  tests_failed;
    string               cur_test;

    rvc_decoder dut0 (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_flush      (i_flush),
        .i_pc         (i_pc),
        .i_instr      (i_instr),
        .i_load_fault (i_load_fault),
        .i_page_fault (i_page_fault),
        .o_dec        (o_dec)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // memory and word attributes follow from the operation alone
    function automatic rvc_pkg::rvc_dec_t expect_rec(
        input rvc_pkg::isa_fmt_e fmt, input rvc_pkg::rvc_op_e op,
        input rvc_pkg::reg_addr_t r1, input rvc_pkg::reg_addr_t r2,
        input rvc_pkg::reg_addr_t wa, input rvc_pkg::xlen_t imm);
        rvc_pkg::rvc_dec_t e;
        e = '0;
        e.fmt = fmt;
        e.op = op;
        e.radr1 = r1;
        e.radr2 = r2;
        e.waddr = wa;
        e.imm = imm;
        e.memop_load = op inside {rvc_pkg::OP_LW, rvc_pkg::OP_LD};
        e.memop_store = op inside {rvc_pkg::OP_SW, rvc_pkg::OP_SD};
        e.memop_sign_ext = e.memop_load;
        e.memop_size = (op inside {rvc_pkg::OP_LW, rvc_pkg::OP_SW}) ?
                       rvc_pkg::MEMOP_4B : rvc_pkg::MEMOP_8B;
        e.rv32 = op inside {rvc_pkg::OP_ADDW, rvc_pkg::OP_ADDIW, rvc_pkg::OP_SUBW};
        return e;
    endfunction

    function automatic rvc_pkg::rvc_dec_t expect_illegal();
        rvc_pkg::rvc_dec_t e;
        e = expect_rec(rvc_pkg::FMT_NONE, rvc_pkg::OP_NONE, 6'd0, 6'd0, 6'd0, 64'd0);
        e.exception = 1'b1;
        return e;
    endfunction

    task automatic check_field(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            $display("ERR %s got 0x%h expected 0x%h in %s", name, got, exp, cur_test);
            err_count++;
        end
    endtask

    task automatic check_rec(input rvc_pkg::rvc_dec_t exp);
        check_field("pc", 64'(o_dec.pc), 64'(exp.pc));
        check_field("instr", 64'(o_dec.instr), 64'(exp.instr));
        check_field("fmt", 64'(o_dec.fmt), 64'(exp.fmt));
        check_field("op", 64'(o_dec.op), 64'(exp.op));
        check_field("radr1", 64'(o_dec.radr1), 64'(exp.radr1));
        check_field("radr2", 64'(o_dec.radr2), 64'(exp.radr2));
        check_field("waddr", 64'(o_dec.waddr), 64'(exp.waddr));
        check_field("imm", 64'(o_dec.imm), 64'(exp.imm));
        check_field("memop_load", 64'(o_dec.memop_load), 64'(exp.memop_load));
        check_field("memop_store", 64'(o_dec.memop_store), 64'(exp.memop_store));
        check_field("memop_sign_ext", 64'(o_dec.memop_sign_ext), 64'(exp.memop_sign_ext));
        check_field("memop_size", 64'(o_dec.memop_size), 64'(exp.memop_size));
        check_field("rv32", 64'(o_dec.rv32), 64'(exp.rv32));
        check_field("exception", 64'(o_dec.exception), 64'(exp.exception));
        check_field("load_fault", 64'(o_dec.load_fault), 64'(exp.load_fault));
        check_field("page_fault", 64'(o_dec.page_fault), 64'(exp.page_fault));
    endtask

    // drive on a rising edge, check the previous slot at the falling edge
    task automatic send(input rvc_pkg::rvc_instr_t instr, input logic lf, input logic pf,
                        input logic fl, input rvc_pkg::rvc_dec_t exp);
        rvc_pkg::rvc_dec_t e;
        e = exp;
        if (!fl) begin                              // flushed slot stays all zero
            e.pc = next_pc;
            e.instr = instr;
            e.load_fault = lf;
            e.page_fault = pf;
        end
        @(posedge i_clk);
        i_instr <= instr;
        i_pc <= next_pc;
        i_load_fault <= lf;
        i_page_fault <= pf;
        i_flush <= fl;
        next_pc = next_pc + 64'd2;
        @(negedge i_clk);
        if (pend_valid) begin
            check_rec(pend_exp);
        end
        pend_exp = e;
        pend_valid = 1'b1;
    endtask

    task automatic issue(input rvc_pkg::rvc_instr_t instr, input rvc_pkg::rvc_dec_t exp);
        send(instr, 1'b0, 1'b0, 1'b0, exp);
    endtask

    task automatic drain();
        @(posedge i_clk);
        i_flush <= 1'b0;
        @(negedge i_clk);
        if (pend_valid) begin
            check_rec(pend_exp);
        end
        pend_valid = 1'b0;
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        test_err_base = err_count;
    endtask

    task automatic end_test();
        drain();
        tests_run++;
        if (err_count == test_err_base) begin
            $display("test %s ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s FAILED with %0d errors", cur_test, err_count - test_err_base);
        end
    endtask

    `include "rvc_tests.svh"

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, a test is stuck", TIMEOUT_NS);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        i_nrst <= 1'b0;
        i_flush <= 1'b0;
        i_pc <= '0;
        i_instr <= '0;
        i_load_fault <= 1'b0;
        i_page_fault <= 1'b0;
        rng_state = 32'hdbd93254;
        next_pc = 64'h0000_0000_8000_0000;
        pend_exp = '0;
        pend_valid = 1'b0;
        err_count = 0;
        test_err_base = 0;
        tests_run = 0;
        tests_failed = 0;
        test_reset();
        test_quadrant0();
        test_quadrant1_imm();
        test_math_group();
        test_quadrant2();
        test_pipeline();
        $display("summary %0d tests run, %0d failed, %0d errors",
                 tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: verilog/rvc_decoder.sv
/*
 * RVC decoder top level
 * Three combinational quadrant decoders feed one output register stage,
 * one compressed instruction per clock with a single cycle of latency.
 */
`timescale 1ns/1ps

module rvc_decoder (
    input  logic                i_clk,
    input  logic                i_nrst,
    input  logic                i_flush,
    input  rvc_pkg::xlen_t      i_pc,
    input  rvc_pkg::rvc_instr_t i_instr,
    input  logic                i_load_fault,
    input  logic                i_page_fault,
    output rvc_pkg::rvc_dec_t   o_dec
);

    rvc_pkg::dec_fields_t q0_fields;
    rvc_pkg::dec_fields_t q1_fields;
    rvc_pkg::dec_fields_t q2_fields;

    rvc_quadrant0 q0 (
        .i_instr  (i_instr),
        .o_fields (q0_fields)
    );

    rvc_quadrant1 q1 (
        .i_instr  (i_instr),
        .o_fields (q1_fields)
    );

    rvc_quadrant2 q2 (
        .i_instr  (i_instr),
        .o_fields (q2_fields)
    );

    rvc_decode_reg dreg (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_flush      (i_flush),
        .i_pc         (i_pc),
        .i_instr      (i_instr),
        .i_load_fault (i_load_fault),
        .i_page_fault (i_page_fault),
        .i_q0         (q0_fields),
        .i_q1         (q1_fields),
        .i_q2         (q2_fields),
        .o_dec        (o_dec)
    );

endmodule

// File: verilog/rvc_decode_reg.sv
/*
 * RVC decode output register
 * Picks the quadrant result from instruction bits 1:0, adds the memory
 * and word attributes, and registers the record with flush.
 */
`timescale 1ns/1ps

module rvc_decode_reg (
    input  logic                 i_clk,
    input  logic                 i_nrst,
    input  logic                 i_flush,
    input  rvc_pkg::xlen_t       i_pc,
    input  rvc_pkg::rvc_instr_t  i_instr,
    input  logic                 i_load_fault,
    input  logic                 i_page_fault,
    input  rvc_pkg::dec_fields_t i_q0,
    input  rvc_pkg::dec_fields_t i_q1,
    input  rvc_pkg::dec_fields_t i_q2,
    output rvc_pkg::rvc_dec_t    o_dec
);

    rvc_pkg::dec_fields_t sel;
    rvc_pkg::rvc_dec_t    dec_next;

    always_comb begin
        case (i_instr[1:0])
            2'b00: sel = i_q0;
            2'b01: sel = i_q1;
            2'b10: sel = i_q2;
            default: begin                                  // 32-bit opcode space
                sel = '0;
                sel.illegal = 1'b1;
            end
        endcase
    end

    always_comb begin
        dec_next.pc = i_pc;
        dec_next.instr = i_instr;
        dec_next.fmt = sel.fmt;
        dec_next.op = sel.op;
        dec_next.radr1 = sel.radr1;
        dec_next.radr2 = sel.radr2;
        dec_next.waddr = sel.waddr;
        dec_next.imm = sel.imm;
        dec_next.memop_load = (sel.op == rvc_pkg::OP_LW) || (sel.op == rvc_pkg::OP_LD);
        dec_next.memop_store = (sel.op == rvc_pkg::OP_SW) || (sel.op == rvc_pkg::OP_SD);
        dec_next.memop_sign_ext = dec_next.memop_load;   // all RVC loads are signed
        if ((sel.op == rvc_pkg::OP_LW) || (sel.op == rvc_pkg::OP_SW)) begin
            dec_next.memop_size = rvc_pkg::MEMOP_4B;
        end else begin
            dec_next.memop_size = rvc_pkg::MEMOP_8B;
        end
        dec_next.rv32 = (sel.op == rvc_pkg::OP_ADDW) || (sel.op == rvc_pkg::OP_ADDIW)
                        || (sel.op == rvc_pkg::OP_SUBW);
        dec_next.exception = sel.illegal;
        dec_next.load_fault = i_load_fault;
        dec_next.page_fault = i_page_fault;
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_dec <= '0;
        end else if (i_flush) begin
            o_dec <= '0;                                    // drop the decoded slot
        end else begin
            o_dec <= dec_next;
        end
    end

    // a store never writes back a register
    a_st_no_waddr: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_dec.memop_store |-> (o_dec.waddr == '0));

    // quadrant stages clear every field on an illegal encoding
    a_exc_no_op: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_dec.exception |-> (o_dec.op == rvc_pkg::OP_NONE));

endmodule

// File: verilog/rvc_quadrant2.sv
/*
 * RVC quadrant 2 decode
 * SLLI, stack-relative loads and stores, and the JR/MV/EBREAK/JALR/ADD group.
 */
`timescale 1ns/1ps

module rvc_quadrant2 (
    input  rvc_pkg::rvc_instr_t  i_instr,
    output rvc_pkg::dec_fields_t o_fields
);

    rvc_pkg::reg_addr_t rd_full;
    rvc_pkg::reg_addr_t rs2_full;

    assign rd_full  = {1'b0, i_instr[11:7]};
    assign rs2_full = {1'b0, i_instr[6:2]};

    always_comb begin
        rvc_pkg::dec_fields_t f;

        f = '0;
        case (i_instr[15:13])
            3'b000: begin                                   // slli
                f.fmt = rvc_pkg::FMT_I;
                f.op = rvc_pkg::OP_SLLI;
                f.radr1 = rd_full;
                f.waddr = rd_full;
                f.imm[5:0] = {i_instr[12], i_instr[6:2]};
            end
            3'b010: begin                                   // lwsp
                f.fmt = rvc_pkg::FMT_I;
                f.op = rvc_pkg::OP_LW;
                f.radr1 = rvc_pkg::REG_SP;
                f.waddr = rd_full;
                f.imm[7:2] = {i_instr[3:2], i_instr[12], i_instr[6:4]};
            end
            3'b011: begin                                   // ldsp
                f.fmt = rvc_pkg::FMT_I;
                f.op = rvc_pkg::OP_LD;
                f.radr1 = rvc_pkg::REG_SP;
                f.waddr = rd_full;
                f.imm[8:3] = {i_instr[4:2], i_instr[12], i_instr[6:5]};
            end
            3'b100: begin
                f.fmt = rvc_pkg::FMT_I;
                if (rs2_full == '0) begin
                    if (!i_instr[12]) begin                 // jr
                        f.op = rvc_pkg::OP_JALR;
                        f.radr1 = rd_full;
                    end else if (rd_full == '0) begin
                        f.op = rvc_pkg::OP_EBREAK;
                    end else begin                          // jalr, link in ra
                        f.op = rvc_pkg::OP_JALR;
                        f.radr1 = rd_full;
                        f.waddr = rvc_pkg::REG_RA;
                    end
                end else if (!i_instr[12]) begin            // mv as addi rd, rs2, 0
                    f.op = rvc_pkg::OP_ADDI;
                    f.radr1 = rs2_full;
                    f.waddr = rd_full;
                end else begin                              // add
                    f.fmt = rvc_pkg::FMT_R;
                    f.op = rvc_pkg::OP_ADD;
                    f.radr1 = rd_full;
                    f.radr2 = rs2_full;
                    f.waddr = rd_full;
                end
            end
            3'b110: begin                                   // swsp
                f.fmt = rvc_pkg::FMT_S;
                f.op = rvc_pkg::OP_SW;
                f.radr1 = rvc_pkg::REG_SP;
                f.radr2 = rs2_full;
                f.imm[7:2] = {i_instr[8:7], i_instr[12:9]};
            end
            3'b111: begin                                   // sdsp
                f.fmt = rvc_pkg::FMT_S;
                f.op = rvc_pkg::OP_SD;
                f.radr1 = rvc_pkg::REG_SP;
                f.radr2 = rs2_full;
                f.imm[8:3] = {i_instr[9:7], i_instr[12:10]};
            end
            default: f.illegal = 1'b1;                      // fldsp/fsdsp
        endcase
        o_fields = f;
    end

endmodule

// File: verilog/rvc_quadrant1.sv
/*
 * RVC quadrant 1 decode
 * Immediate arithmetic, LI, LUI/ADDI16SP, the math group, J and the
 * compare-with-zero branches. Immediates sign-extend from bit 12.
 */
`timescale 1ns/1ps

module rvc_quadrant1 (
    input  rvc_pkg::rvc_instr_t  i_instr,
    output rvc_pkg::dec_fields_t o_fields
);

    rvc_pkg::reg_addr_t rd_full;
    rvc_pkg::reg_addr_t rs1_prime;
    rvc_pkg::reg_addr_t rs2_prime;
    rvc_pkg::xlen_t     imm6_s;                         // common 6-bit signed imm
    rvc_pkg::xlen_t     imm_j;
    rvc_pkg::xlen_t     imm_b;

    assign rd_full   = {1'b0, i_instr[11:7]};
    assign rs1_prime = rvc_pkg::prime_reg(i_instr[9:7]);
    assign rs2_prime = rvc_pkg::prime_reg(i_instr[4:2]);
    assign imm6_s    = rvc_pkg::xlen_t'($signed({i_instr[12], i_instr[6:2]}));
    assign imm_j     = rvc_pkg::xlen_t'($signed({i_instr[12], i_instr[8], i_instr[10:9],
                           i_instr[6], i_instr[7], i_instr[2], i_instr[11],
                           i_instr[5:3], 1'b0}));
    assign imm_b     = rvc_pkg::xlen_t'($signed({i_instr[12], i_instr[6:5], i_instr[2],
                           i_instr[11:10], i_instr[4:3], 1'b0}));

    always_comb begin
        rvc_pkg::dec_fields_t f;

        f = '0;
        case (i_instr[15:13])
            3'b000, 3'b001: begin                           // addi / addiw
                f.fmt = rvc_pkg::FMT_I;
                f.op = i_instr[13] ? rvc_pkg::OP_ADDIW : rvc_pkg::OP_ADDI;
                f.radr1 = rd_full;
                f.waddr = rd_full;
                f.imm = imm6_s;
            end
            3'b010: begin                                   // li, rs1 = x0
                f.fmt = rvc_pkg::FMT_I;
                f.op = rvc_pkg::OP_ADDI;
                f.waddr = rd_full;
                f.imm = imm6_s;
            end
            3'b011: begin
                if (rd_full == rvc_pkg::REG_SP) begin       // addi16sp
                    f.fmt = rvc_pkg::FMT_I;
                    f.op = rvc_pkg::OP_ADDI;
                    f.radr1 = rvc_pkg::REG_SP;
                    f.waddr = rvc_pkg::REG_SP;
                    f.imm = rvc_pkg::xlen_t'($signed({i_instr[12], i_instr[4:3],
                                i_instr[5], i_instr[2], i_instr[6], 4'b0000}));
                end else begin                              // lui
                    f.fmt = rvc_pkg::FMT_U;
                    f.op = rvc_pkg::OP_LUI;
                    f.waddr = rd_full;
                    f.imm = rvc_pkg::xlen_t'($signed({i_instr[12], i_instr[6:2], 12'h000}));
                end
            end
            3'b100: begin                                   // math group
                f.radr1 = rs1_prime;
                f.waddr = rs1_prime;
                case (i_instr[11:10])
                    2'b00, 2'b01: begin                     // srli / srai
                        f.fmt = rvc_pkg::FMT_I;
                        f.op = i_instr[10] ? rvc_pkg::OP_SRAI : rvc_pkg::OP_SRLI;
                        f.imm[5:0] = {i_instr[12], i_instr[6:2]};
                    end
                    2'b10: begin
                        f.fmt = rvc_pkg::FMT_I;
                        f.op = rvc_pkg::OP_ANDI;
                        f.imm = imm6_s;
                    end
                    default: begin                          // register-register
                        f.fmt = rvc_pkg::FMT_R;
                        f.radr2 = rs2_prime;
                        case ({i_instr[12], i_instr[6:5]})
                            3'b000: f.op = rvc_pkg::OP_SUB;
                            3'b001: f.op = rvc_pkg::OP_XOR;
                            3'b010: f.op = rvc_pkg::OP_OR;
                            3'b011: f.op = rvc_pkg::OP_AND;
                            3'b100: f.op = rvc_pkg::OP_SUBW;
                            3'b101: f.op = rvc_pkg::OP_ADDW;
                            default: begin                  // reserved codes
                                f = '0;
                                f.illegal = 1'b1;
                            end
                        endcase
                    end
                endcase
            end
            3'b101: begin                                   // j, jal with rd = x0
                f.fmt = rvc_pkg::FMT_UJ;
                f.op = rvc_pkg::OP_JAL;
                f.imm = imm_j;
            end
            default: begin                                  // beqz / bnez
                f.fmt = rvc_pkg::FMT_SB;
                f.op = i_instr[13] ? rvc_pkg::OP_BNE : rvc_pkg::OP_BEQ;
                f.radr1 = rs1_prime;
                f.imm = imm_b;
            end
        endcase
        o_fields = f;
    end

endmodule

// File: verilog/rvc_quadrant0.sv
/*
 * RVC quadrant 0 decode
 * ADDI4SPN and the register-based LW/LD/SW/SD with scaled unsigned offsets.
 */
`timescale 1ns/1ps

module rvc_quadrant0 (
    input  rvc_pkg::rvc_instr_t  i_instr,
    output rvc_pkg::dec_fields_t o_fields
);

    always_comb begin
        rvc_pkg::dec_fields_t f;

        f = '0;
        case (i_instr[15:13])
            3'b000: begin                                   // addi4spn
                f.fmt = rvc_pkg::FMT_I;
                f.op = rvc_pkg::OP_ADDI;
                f.radr1 = rvc_pkg::REG_SP;
                f.waddr = rvc_pkg::prime_reg(i_instr[4:2]);
                f.imm[9:2] = {i_instr[10:7], i_instr[12:11], i_instr[5], i_instr[6]};
            end
            3'b010: begin                                   // lw
                f.fmt = rvc_pkg::FMT_I;
                f.op = rvc_pkg::OP_LW;
                f.radr1 = rvc_pkg::prime_reg(i_instr[9:7]);
                f.waddr = rvc_pkg::prime_reg(i_instr[4:2]);
                f.imm[6:2] = {i_instr[5], i_instr[12:10], i_instr[6]};
            end
            3'b011: begin                                   // ld
                f.fmt = rvc_pkg::FMT_I;
                f.op = rvc_pkg::OP_LD;
                f.radr1 = rvc_pkg::prime_reg(i_instr[9:7]);
                f.waddr = rvc_pkg::prime_reg(i_instr[4:2]);
                f.imm[7:3] = {i_instr[6:5], i_instr[12:10]};
            end
            3'b110: begin                                   // sw
                f.fmt = rvc_pkg::FMT_S;
                f.op = rvc_pkg::OP_SW;
                f.radr1 = rvc_pkg::prime_reg(i_instr[9:7]);
                f.radr2 = rvc_pkg::prime_reg(i_instr[4:2]);
                f.imm[6:2] = {i_instr[5], i_instr[12:10], i_instr[6]};
            end
            3'b111: begin                                   // sd
                f.fmt = rvc_pkg::FMT_S;
                f.op = rvc_pkg::OP_SD;
                f.radr1 = rvc_pkg::prime_reg(i_instr[9:7]);
                f.radr2 = rvc_pkg::prime_reg(i_instr[4:2]);
                f.imm[7:3] = {i_instr[6:5], i_instr[12:10]};
            end
            default: f.illegal = 1'b1;                      // fld/fsd and reserved
        endcase
        o_fields = f;
    end

endmodule

// File: verilog/rvc_pkg.sv
/*
 * RVC decoder shared definitions
 * Widths, format and operation encodings, and the packed records
 * passed from the quadrant stages to the output register.
 */
package rvc_pkg;

    localparam int XLEN = 64;                   // LD/SD/ADDIW need RV64C

    typedef logic [XLEN-1:0] xlen_t;            // pc and immediate
    typedef logic [15:0] rvc_instr_t;           // one compressed instruction
    typedef logic [5:0] reg_addr_t;             // msb selects FPU bank, unused here

    localparam reg_addr_t REG_RA = 6'd1;        // link register
    localparam reg_addr_t REG_SP = 6'd2;        // stack pointer
    localparam reg_addr_t PRIME_BASE = 6'd8;    // x8..x15 for 3-bit fields

    typedef enum logic [2:0] {
        FMT_NONE, FMT_R, FMT_I, FMT_S, FMT_SB, FMT_U, FMT_UJ
    } isa_fmt_e;

    typedef enum logic [4:0] {
        OP_NONE, OP_ADDI, OP_ADDIW, OP_SLLI, OP_SRLI, OP_SRAI, OP_ANDI,
        OP_LUI, OP_LW, OP_LD, OP_SW, OP_SD,
        OP_SUB, OP_XOR, OP_OR, OP_AND, OP_SUBW, OP_ADDW, OP_ADD,
        OP_JAL, OP_JALR, OP_BEQ, OP_BNE, OP_EBREAK
    } rvc_op_e;

    typedef enum logic [1:0] {
        MEMOP_4B = 2'd2,
        MEMOP_8B = 2'd3
    } memop_size_e;

    // result of one quadrant stage
    typedef struct packed {
        isa_fmt_e  fmt;
        rvc_op_e   op;
        reg_addr_t radr1;
        reg_addr_t radr2;
        reg_addr_t waddr;
        xlen_t     imm;
        logic      illegal;                     // reserved or unsupported encoding
    } dec_fields_t;

    // registered decoder output
    typedef struct packed {
        xlen_t       pc;
        rvc_instr_t  instr;
        isa_fmt_e    fmt;
        rvc_op_e     op;
        reg_addr_t   radr1;
        reg_addr_t   radr2;
        reg_addr_t   waddr;
        xlen_t       imm;
        logic        memop_load;
        logic        memop_store;
        logic        memop_sign_ext;
        memop_size_e memop_size;
        logic        rv32;                      // 32-bit word operation
        logic        exception;
        logic        load_fault;
        logic        page_fault;
    } rvc_dec_t;

    // maps a 3-bit compressed register field onto x8..x15
    function automatic reg_addr_t prime_reg(input logic [2:0] field);
        return PRIME_BASE + reg_addr_t'(field);
    endfunction

endpackage
